//--- hw/proc_defines.svh
// Processor sizing macros
// Word width, register count and memory depths used by RTL and testbench

`ifndef PROC_DEFINES_SVH
`define PROC_DEFINES_SVH

// Data and instruction word
`define WORD_W 16

// General purpose registers
`define REG_CNT 8

// Memory sizes in words
`define IMEM_DEPTH 256
`define DMEM_DEPTH 256

// Memory address bits taken from the low end of a value
`define ADDR_W 8

`endif

//--- hw/proc_pkg.sv
// Processor types
// Opcodes, decoded control and the payloads carried between pipeline stages

`include "proc_defines.svh"

package proc_pkg;

	typedef logic [`WORD_W-1:0] word_t;
	typedef logic [$clog2(`REG_CNT)-1:0] reg_idx_t;

	// Instruction bits 15:12
	typedef enum logic [3:0] {
		OP_NOP  = 4'd0,
		OP_ADD  = 4'd1,
		OP_SUB  = 4'd2,
		OP_AND  = 4'd3,
		OP_XOR  = 4'd4,
		OP_ADDI = 4'd5,
		OP_LD   = 4'd6,
		OP_ST   = 4'd7,
		OP_BEQZ = 4'd8,
		OP_HALT = 4'd15
	} opcode_e;

	typedef enum logic [1:0] {
		ALU_ADD = 2'd0,
		ALU_SUB = 2'd1,
		ALU_AND = 2'd2,
		ALU_XOR = 2'd3
	} alu_op_e;

	typedef struct packed {
		alu_op_e alu_op;
		logic    use_imm;
		logic    mem_rd;
		logic    mem_wr;
		logic    reg_wr;
		logic    is_branch;
		logic    is_halt;
	} ctrl_t;

	typedef struct packed {
		word_t pc;
		word_t instr;
	} if_id_t;

	typedef struct packed {
		word_t    pc;
		ctrl_t    ctrl;
		reg_idx_t rs;
		reg_idx_t rt;
		reg_idx_t rd;
		word_t    op_a;
		word_t    op_b;
		word_t    st_data;
		word_t    imm;
	} id_ex_t;

	typedef struct packed {
		ctrl_t    ctrl;
		reg_idx_t rd;
		word_t    result;
		word_t    st_data;
	} ex_mem_t;

	typedef struct packed {
		logic     reg_wr;
		reg_idx_t rd;
		word_t    result;
		logic     is_halt;
	} mem_wb_t;

	// One beat per retired register write
	typedef struct packed {
		logic     valid;
		reg_idx_t rd;
		word_t    data;
	} wb_trace_t;

endpackage

//--- hw/pipe_reg.sv
// Pipeline register
// Holds one stage payload and its valid bit, with stall hold and flush clear

`timescale 1ns/1ps

module pipe_reg #(
	parameter type payload_t = logic
) (
	input  logic     clk,
	input  logic     rst_n,
	input  logic     stall,
	input  logic     flush,
	input  logic     in_valid,
	input  payload_t in_data,
	output logic     out_valid,
	output payload_t out_data
);

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			out_valid <= 1'b0;
			out_data  <= '0;
		end else if (flush) begin
			// Bubble with the data kept
			out_valid <= 1'b0;
		end else if (!stall) begin
			out_valid <= in_valid;
			out_data  <= in_data;
		end
	end

endmodule

//--- hw/fetch.sv
// Fetch stage
// Program counter and instruction memory with a load port for use while stopped

`timescale 1ns/1ps

`include "proc_defines.svh"

module fetch (
	input  logic                 clk,
	input  logic                 rst_n,
	input  logic                 run,
	input  logic                 load_en,
	input  logic [`ADDR_W-1:0]   load_addr,
	input  logic [`WORD_W-1:0]   load_data,
	input  logic                 hazard_stall,
	input  logic                 halt_seen,
	input  logic                 redirect,
	input  logic [`WORD_W-1:0]   redirect_pc,
	output logic                 fetch_valid,
	output proc_pkg::if_id_t     fetch_out
);

	logic [`WORD_W-1:0] imem [`IMEM_DEPTH];
	logic [`WORD_W-1:0] pc;
	logic               running;
	logic               stopped;

	// Program load only while the core is not running
	always_ff @(posedge clk) begin
		if (load_en && !run)
			imem[load_addr] <= load_data;
	end

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			pc      <= '0;
			running <= 1'b0;
			stopped <= 1'b0;
		end else begin
			running <= run;
			// HALT in decode freezes fetch for good
			if (halt_seen)
				stopped <= 1'b1;
			if (redirect)
				pc <= redirect_pc;
			else if (running && !hazard_stall && !halt_seen && !stopped)
				pc <= pc + `WORD_W'(1);
		end
	end

	assign fetch_valid     = running && !halt_seen && !stopped;
	assign fetch_out.pc    = pc;
	assign fetch_out.instr = imem[pc[`ADDR_W-1:0]];

endmodule

//--- hw/decode.sv
// Decode stage
// Opcode decode, write-before-read register file, load-use stall and illegal opcode flag

`timescale 1ns/1ps

`include "proc_defines.svh"

module decode (
	input  logic                clk,
	input  logic                rst_n,
	input  logic                dec_valid,
	input  proc_pkg::if_id_t    dec_in,
	input  logic                redirect,
	input  logic                ex_valid,
	input  proc_pkg::reg_idx_t  ex_rd,
	input  logic                ex_is_load,
	input  logic                wb_valid,
	input  proc_pkg::mem_wb_t   wb_in,
	output logic                id_valid,
	output proc_pkg::id_ex_t    id_out,
	output logic                hazard_stall,
	output logic                halt_seen,
	output logic                err
);
	import proc_pkg::*;

	word_t    regs [`REG_CNT];
	opcode_e  op;
	reg_idx_t rd;
	reg_idx_t rs;
	reg_idx_t rt;
	word_t    imm;
	ctrl_t    ctrl;
	logic     legal;
	logic     use_rs;
	logic     use_rt;
	logic     use_rd;

	// Write-back data bypasses the array in the same cycle
	function automatic word_t rf_read(input reg_idx_t idx);
		word_t val;
		if (idx == '0)
			val = '0;
		else if (wb_valid && wb_in.reg_wr && wb_in.rd == idx)
			val = wb_in.result;
		else
			val = regs[idx];
		return val;
	endfunction

	assign op  = opcode_e'(dec_in.instr[15:12]);
	assign rd  = dec_in.instr[11:9];
	assign rs  = dec_in.instr[8:6];
	assign rt  = dec_in.instr[5:3];
	assign imm = {{(`WORD_W-6){dec_in.instr[5]}}, dec_in.instr[5:0]};

	always_comb begin
		ctrl   = '0;
		legal  = 1'b1;
		use_rs = 1'b0;
		use_rt = 1'b0;
		use_rd = 1'b0;
		case (op)
			OP_SUB:  ctrl.alu_op = ALU_SUB;
			OP_AND:  ctrl.alu_op = ALU_AND;
			OP_XOR:  ctrl.alu_op = ALU_XOR;
			default: ctrl.alu_op = ALU_ADD;
		endcase
		case (op)
			OP_NOP: ;
			OP_ADD, OP_SUB, OP_AND, OP_XOR: begin
				ctrl.reg_wr = 1'b1;
				use_rs      = 1'b1;
				use_rt      = 1'b1;
			end
			OP_ADDI: begin
				ctrl.reg_wr  = 1'b1;
				ctrl.use_imm = 1'b1;
				use_rs       = 1'b1;
			end
			OP_LD: begin
				ctrl.reg_wr  = 1'b1;
				ctrl.mem_rd  = 1'b1;
				ctrl.use_imm = 1'b1;
				use_rs       = 1'b1;
			end
			OP_ST: begin
				// Store data comes from the rd field
				ctrl.mem_wr  = 1'b1;
				ctrl.use_imm = 1'b1;
				use_rs       = 1'b1;
				use_rd       = 1'b1;
			end
			OP_BEQZ: begin
				ctrl.is_branch = 1'b1;
				use_rs         = 1'b1;
			end
			OP_HALT: ctrl.is_halt = 1'b1;
			default: legal = 1'b0;
		endcase
		// r0 is never written
		if (rd == '0)
			ctrl.reg_wr = 1'b0;
	end

	always_comb begin
		id_out.pc      = dec_in.pc;
		id_out.ctrl    = ctrl;
		id_out.rs      = rs;
		id_out.rt      = rt;
		id_out.rd      = rd;
		id_out.op_a    = rf_read(rs);
		id_out.op_b    = rf_read(rt);
		id_out.st_data = rf_read(rd);
		id_out.imm     = imm;
	end

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			for (int i = 0; i < `REG_CNT; i++)
				regs[i] <= '0;
		end else if (wb_valid && wb_in.reg_wr) begin
			regs[wb_in.rd] <= wb_in.result;
		end
	end

	// Load in execute feeding this instruction
	assign hazard_stall = dec_valid && ex_valid && ex_is_load && (ex_rd != '0) &&
		((use_rs && rs == ex_rd) || (use_rt && rt == ex_rd) || (use_rd && rd == ex_rd));

	assign halt_seen = dec_valid && ctrl.is_halt && !redirect;
	assign id_valid  = dec_valid && legal;

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n)
			err <= 1'b0;
		else if (dec_valid && !legal && !redirect)
			err <= 1'b1;
	end

endmodule

//--- hw/execute.sv
// Execute stage
// Operand forwarding, ALU, memory address and BEQZ resolution

`timescale 1ns/1ps

`include "proc_defines.svh"

module execute (
	input  logic                ex_valid,
	input  proc_pkg::id_ex_t    ex_in,
	input  logic                mem_valid,
	input  proc_pkg::ex_mem_t   mem_in,
	input  logic                wb_valid,
	input  proc_pkg::mem_wb_t   wb_in,
	output proc_pkg::ex_mem_t   ex_out,
	output logic                redirect,
	output logic [`WORD_W-1:0]  redirect_pc
);
	import proc_pkg::*;

	word_t op_a;
	word_t alu_b;
	word_t st_data;
	word_t alu_y;

	// EX/MEM is younger than MEM/WB so it is checked first
	function automatic word_t fwd(input reg_idx_t idx, input word_t rf_val);
		word_t val;
		if (mem_valid && mem_in.ctrl.reg_wr && mem_in.rd == idx)
			val = mem_in.result;
		else if (wb_valid && wb_in.reg_wr && wb_in.rd == idx)
			val = wb_in.result;
		else
			val = rf_val;
		return val;
	endfunction

	always_comb begin
		op_a    = fwd(ex_in.rs, ex_in.op_a);
		alu_b   = ex_in.ctrl.use_imm ? ex_in.imm : fwd(ex_in.rt, ex_in.op_b);
		st_data = fwd(ex_in.rd, ex_in.st_data);
		// Also the LD and ST address
		case (ex_in.ctrl.alu_op)
			ALU_ADD: alu_y = op_a + alu_b;
			ALU_SUB: alu_y = op_a - alu_b;
			ALU_AND: alu_y = op_a & alu_b;
			default: alu_y = op_a ^ alu_b;
		endcase
	end

	always_comb begin
		ex_out.ctrl    = ex_in.ctrl;
		ex_out.rd      = ex_in.rd;
		ex_out.result  = alu_y;
		ex_out.st_data = st_data;
	end

	// Branch target is relative to the next instruction
	assign redirect    = ex_valid && ex_in.ctrl.is_branch && (op_a == '0);
	assign redirect_pc = ex_in.pc + ex_in.imm + `WORD_W'(1);

endmodule

//--- hw/memory.sv
// Memory stage
// Data memory with asynchronous read and selection of the write-back value

`timescale 1ns/1ps

`include "proc_defines.svh"

module memory (
	input  logic              clk,
	input  logic              rst_n,
	input  logic              mem_valid,
	input  proc_pkg::ex_mem_t mem_in,
	output proc_pkg::mem_wb_t wb_out
);

	logic [`WORD_W-1:0] dmem [`DMEM_DEPTH];
	logic [`ADDR_W-1:0] addr;
	logic [`WORD_W-1:0] rd_data;

	assign addr    = mem_in.result[`ADDR_W-1:0];
	assign rd_data = dmem[addr];

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			for (int i = 0; i < `DMEM_DEPTH; i++)
				dmem[i] <= '0;
		end else if (mem_valid && mem_in.ctrl.mem_wr) begin
			dmem[addr] <= mem_in.st_data;
		end
	end

	always_comb begin
		wb_out.reg_wr  = mem_in.ctrl.reg_wr;
		wb_out.rd      = mem_in.rd;
		// Load data or ALU result
		wb_out.result  = mem_in.ctrl.mem_rd ? rd_data : mem_in.result;
		wb_out.is_halt = mem_in.ctrl.is_halt;
	end

endmodule

//--- hw/proc.sv
// Five-stage pipelined processor top level
// Fetch, decode, execute and memory stages joined by four pipeline registers

`timescale 1ns/1ps

`include "proc_defines.svh"

module proc (
	input  logic                 clk,
	input  logic                 rst_n,
	input  logic                 load_en,
	input  logic [`ADDR_W-1:0]   load_addr,
	input  logic [`WORD_W-1:0]   load_data,
	input  logic                 run,
	output logic                 halt,
	output logic                 err,
	output proc_pkg::wb_trace_t  trace
);
	import proc_pkg::*;

	if_id_t  fetch_out, if_id_q;
	id_ex_t  id_out, id_ex_q;
	ex_mem_t ex_out, ex_mem_q;
	mem_wb_t wb_out, mem_wb_q;

	logic    fetch_valid, if_id_valid;
	logic    id_valid, id_ex_valid;
	logic    ex_mem_valid, mem_wb_valid;
	logic    hazard_stall, halt_seen, redirect;
	word_t   redirect_pc;

	fetch fetch_inst (
		.clk(clk), .rst_n(rst_n), .run(run),
		.load_en(load_en), .load_addr(load_addr), .load_data(load_data),
		.hazard_stall(hazard_stall), .halt_seen(halt_seen),
		.redirect(redirect), .redirect_pc(redirect_pc),
		.fetch_valid(fetch_valid), .fetch_out(fetch_out)
	);

	pipe_reg #(.payload_t(if_id_t)) if_id (
		.clk(clk), .rst_n(rst_n), .stall(hazard_stall), .flush(redirect),
		.in_valid(fetch_valid), .in_data(fetch_out),
		.out_valid(if_id_valid), .out_data(if_id_q)
	);

	decode decode_inst (
		.clk(clk), .rst_n(rst_n),
		.dec_valid(if_id_valid), .dec_in(if_id_q), .redirect(redirect),
		.ex_valid(id_ex_valid), .ex_rd(id_ex_q.rd), .ex_is_load(id_ex_q.ctrl.mem_rd),
		.wb_valid(mem_wb_valid), .wb_in(mem_wb_q),
		.id_valid(id_valid), .id_out(id_out),
		.hazard_stall(hazard_stall), .halt_seen(halt_seen), .err(err)
	);

	// Load-use stall leaves a bubble behind the held instruction
	pipe_reg #(.payload_t(id_ex_t)) id_ex (
		.clk(clk), .rst_n(rst_n), .stall(1'b0), .flush(hazard_stall | redirect),
		.in_valid(id_valid), .in_data(id_out),
		.out_valid(id_ex_valid), .out_data(id_ex_q)
	);

	execute execute_inst (
		.ex_valid(id_ex_valid), .ex_in(id_ex_q),
		.mem_valid(ex_mem_valid), .mem_in(ex_mem_q),
		.wb_valid(mem_wb_valid), .wb_in(mem_wb_q),
		.ex_out(ex_out), .redirect(redirect), .redirect_pc(redirect_pc)
	);

	pipe_reg #(.payload_t(ex_mem_t)) ex_mem (
		.clk(clk), .rst_n(rst_n), .stall(1'b0), .flush(1'b0),
		.in_valid(id_ex_valid), .in_data(ex_out),
		.out_valid(ex_mem_valid), .out_data(ex_mem_q)
	);

	memory memory_inst (
		.clk(clk), .rst_n(rst_n),
		.mem_valid(ex_mem_valid), .mem_in(ex_mem_q), .wb_out(wb_out)
	);

	// Retired HALT is held here until reset
	pipe_reg #(.payload_t(mem_wb_t)) mem_wb (
		.clk(clk), .rst_n(rst_n), .stall(halt), .flush(1'b0),
		.in_valid(ex_mem_valid), .in_data(wb_out),
		.out_valid(mem_wb_valid), .out_data(mem_wb_q)
	);

	assign halt  = mem_wb_valid && mem_wb_q.is_halt;
	assign trace = '{valid: mem_wb_valid && mem_wb_q.reg_wr,
		rd: mem_wb_q.rd, data: mem_wb_q.result};

endmodule

//--- test/proc_checker.sv
// Processor checker
// Concurrent assertions on halt, trace and err bound into the processor top level

`timescale 1ns/1ps

module proc_checker (
	input logic                clk,
	input logic                rst_n,
	input logic                halt,
	input logic                err,
	input proc_pkg::wb_trace_t trace
);

	// Number of failed assertions
	int fail_cnt = 0;

	halt_sticky: assert property (@(posedge clk) disable iff (!rst_n) halt |=> halt)
		else begin
			fail_cnt++;
			$error("halt dropped without a reset");
		end

	no_trace_at_halt: assert property (@(posedge clk) disable iff (!rst_n)
		!(halt && trace.valid))
		else begin
			fail_cnt++;
			$error("trace.valid high while halt is high");
		end

	trace_rd_nonzero: assert property (@(posedge clk) disable iff (!rst_n)
		trace.valid |-> trace.rd != '0)
		else begin
			fail_cnt++;
			$error("trace reports a write to r0");
		end

	err_sticky: assert property (@(posedge clk) disable iff (!rst_n) err |=> err)
		else begin
			fail_cnt++;
			$error("err dropped without a reset");
		end

endmodule

bind proc proc_checker proc_checker_inst (
	.clk(clk), .rst_n(rst_n), .halt(halt), .err(err), .trace(trace)
);

//--- test/proc_tb.sv
// Processor testbench
// Runs directed and random programs and checks the write-back trace against an ISA model

`timescale 1ns/1ps

`include "proc_defines.svh"

module proc_tb;
	import proc_pkg::*;

	localparam int HALT_TIMEOUT = 600;
	localparam int PROG_MAX     = 64;

	logic                clk;
	logic                rst_n;
	logic                load_en;
	logic [`ADDR_W-1:0]  load_addr;
	logic [`WORD_W-1:0]  load_data;
	logic                run;
	logic                halt;
	logic                err;
	wb_trace_t           trace;

	logic [15:0] prog [PROG_MAX];
	int          prog_len;
	wb_trace_t   exp_q [$];
	logic [15:0] lfsr_state;
	logic        checking;
	int          mismatch_errs;
	int          missing_errs;
	int          extra_errs;
	int          timeout_errs;
	int          other_errs;
	int          total_errs;

	proc proc_inst (
		.clk(clk), .rst_n(rst_n), .load_en(load_en), .load_addr(load_addr),
		.load_data(load_data), .run(run), .halt(halt), .err(err), .trace(trace)
	);

	initial begin
		clk = 1'b0;
		forever #50 clk = ~clk;
	end

	// Galois LFSR stepped once per bit
	function automatic logic lfsr_bit();
		logic out;
		out = lfsr_state[0];
		lfsr_state = lfsr_state >> 1;
		if (out)
			lfsr_state = lfsr_state ^ 16'hB400;
		return out;
	endfunction

	function automatic int rand_bits(input int n);
		int v;
		v = 0;
		for (int i = 0; i < n; i++)
			v = (v << 1) | int'(lfsr_bit());
		return v;
	endfunction

	function automatic logic [15:0] enc_r(input logic [3:0] op, input int rd, input int rs,
		input int rt);
		return {op, 3'(rd), 3'(rs), 3'(rt), 3'b000};
	endfunction

	function automatic logic [15:0] enc_i(input logic [3:0] op, input int rd, input int rs,
		input int imm);
		return {op, 3'(rd), 3'(rs), 6'(imm)};
	endfunction

	function automatic void add_word(input logic [15:0] w);
		prog[prog_len] = w;
		prog_len++;
	endfunction

	// ISA model of the loaded program with ordered writes into exp_q
	function automatic void run_model(output logic exp_err);
		word_t       regs_m [8];
		word_t       dm [256];
		int          pc;
		int          next_pc;
		int          steps;
		logic        done;
		logic        wr;
		logic [15:0] ins;
		logic [2:0]  rd;
		logic [2:0]  rs;
		logic [2:0]  rt;
		word_t       imm;
		word_t       val;
		word_t       addr;
		wb_trace_t   ent;
		exp_q.delete();
		exp_err = 1'b0;
		for (int i = 0; i < 8; i++)
			regs_m[i] = '0;
		for (int i = 0; i < 256; i++)
			dm[i] = '0;
		pc = 0;
		steps = 0;
		done = 1'b0;
		while (!done && pc < prog_len && steps < 1000) begin
			ins = prog[pc];
			rd = ins[11:9];
			rs = ins[8:6];
			rt = ins[5:3];
			imm = {{10{ins[5]}}, ins[5:0]};
			// Opcodes 1 to 6 write rd
			wr = (ins[15:12] >= 4'd1 && ins[15:12] <= 4'd6);
			val = '0;
			next_pc = pc + 1;
			case (ins[15:12])
				4'd0: ;
				4'd1: val = regs_m[rs] + regs_m[rt];
				4'd2: val = regs_m[rs] - regs_m[rt];
				4'd3: val = regs_m[rs] & regs_m[rt];
				4'd4: val = regs_m[rs] ^ regs_m[rt];
				4'd5: val = regs_m[rs] + imm;
				4'd6: begin
					addr = regs_m[rs] + imm;
					val = dm[addr[7:0]];
				end
				4'd7: begin
					addr = regs_m[rs] + imm;
					dm[addr[7:0]] = regs_m[rd];
				end
				4'd8: begin
					if (regs_m[rs] == '0)
						next_pc = pc + 1 + int'($signed(imm));
				end
				4'd15: done = 1'b1;
				default: exp_err = 1'b1;
			endcase
			if (wr && rd != 3'd0) begin
				regs_m[rd] = val;
				ent.valid = 1'b1;
				ent.rd = rd;
				ent.data = val;
				exp_q.push_back(ent);
			end
			pc = next_pc;
			steps++;
		end
	endfunction

	task automatic apply_reset();
		@(negedge clk);
		rst_n = 1'b0;
		repeat (2) @(negedge clk);
		rst_n = 1'b1;
	endtask

	// Dependent ALU chain over both forwarding paths and the register file bypass
	task automatic build_alu_chain();
		prog_len = 0;
		add_word(enc_i(OP_ADDI, 1, 0, 5));
		add_word(enc_i(OP_ADDI, 2, 1, -3));
		add_word(enc_r(OP_ADD, 3, 1, 2));
		add_word(enc_r(OP_SUB, 4, 3, 1));
		add_word(enc_r(OP_AND, 5, 4, 3));
		add_word(enc_r(OP_XOR, 6, 5, 2));
		add_word(enc_r(OP_ADD, 0, 6, 6));
		add_word(16'h0000);
		add_word(enc_r(OP_ADD, 7, 6, 6));
		add_word(enc_i(OP_ADDI, 1, 7, 31));
		add_word(enc_r(OP_XOR, 2, 1, 3));
		add_word(enc_r(OP_HALT, 0, 0, 0));
	endtask

	task automatic build_load_store();
		prog_len = 0;
		add_word(enc_i(OP_ADDI, 1, 0, 9));
		add_word(enc_i(OP_ADDI, 2, 0, 20));
		add_word(enc_i(OP_ST, 1, 2, 3));
		add_word(enc_i(OP_LD, 3, 2, 3));
		add_word(enc_r(OP_ADD, 4, 3, 3));
		add_word(enc_i(OP_ST, 4, 0, 5));
		add_word(enc_i(OP_LD, 5, 0, 5));
		add_word(enc_i(OP_ST, 5, 2, -1));
		add_word(enc_i(OP_LD, 6, 2, -1));
		add_word(enc_i(OP_LD, 7, 6, 0));
		add_word(enc_i(OP_ADDI, 7, 7, 1));
		add_word(enc_r(OP_HALT, 0, 0, 0));
	endtask

	// Taken and untaken branches with HALT words in the flushed shadow
	task automatic build_branch();
		prog_len = 0;
		add_word(enc_i(OP_ADDI, 2, 0, 4));
		add_word(enc_i(OP_BEQZ, 0, 1, 2));
		add_word(enc_i(OP_ADDI, 3, 0, 7));
		add_word(enc_r(OP_HALT, 0, 0, 0));
		add_word(enc_i(OP_BEQZ, 0, 2, 1));
		add_word(enc_i(OP_ADDI, 4, 0, 11));
		add_word(enc_i(OP_ADDI, 5, 4, 1));
		add_word(enc_i(OP_BEQZ, 0, 0, 3));
		add_word(enc_i(OP_ADDI, 6, 0, 1));
		add_word(enc_i(OP_ADDI, 7, 0, 2));
		add_word(enc_r(OP_HALT, 0, 0, 0));
		add_word(enc_i(OP_ADDI, 3, 5, -2));
		add_word(enc_r(OP_SUB, 6, 2, 2));
		add_word(enc_i(OP_BEQZ, 0, 6, 1));
		add_word(enc_r(OP_HALT, 0, 0, 0));
		add_word(enc_i(OP_ADDI, 1, 6, 3));
		add_word(enc_r(OP_HALT, 0, 0, 0));
	endtask

	task automatic build_illegal();
		prog_len = 0;
		add_word(enc_i(OP_ADDI, 1, 0, 6));
		add_word(16'h9248);
		add_word(enc_r(OP_ADD, 2, 1, 1));
		add_word(16'hA000);
		add_word(enc_i(OP_ADDI, 3, 2, -5));
		add_word(enc_r(OP_HALT, 0, 0, 0));
	endtask

	// Opcode is the 3-bit pick plus one, so 7 maps to BEQZ
	task automatic build_random();
		int          len;
		int          off;
		logic [3:0]  op;
		int          rd;
		int          rs;
		int          low;
		prog_len = 0;
		len = 10 + rand_bits(4);
		for (int i = 0; i < len; i++) begin
			op = 4'(rand_bits(3)) + 4'd1;
			rd = rand_bits(3);
			rs = rand_bits(3);
			low = rand_bits(6);
			if (op == OP_BEQZ) begin
				off = 1 + rand_bits(2) % 3;
				if (i + 1 + off > len)
					add_word(16'h0000);
				else
					add_word(enc_i(OP_BEQZ, 0, rs, off));
			end else if (op == OP_LD || op == OP_ST) begin
				add_word(enc_i(op, rd, rs, low & 7));
			end else begin
				add_word({op, 3'(rd), 3'(rs), 6'(low)});
			end
		end
		add_word(enc_r(OP_HALT, 0, 0, 0));
	endtask

	task automatic run_program(input string name);
		int   cycles;
		logic exp_err;
		run = 1'b0;
		for (int a = 0; a < prog_len + 3; a++) begin
			@(negedge clk);
			load_en   = 1'b1;
			load_addr = `ADDR_W'(a);
			load_data = (a < prog_len) ? prog[a] : 16'h0000;
		end
		@(negedge clk);
		load_en = 1'b0;
		apply_reset();
		run_model(exp_err);
		if (halt !== 1'b0 || err !== 1'b0 || trace.valid !== 1'b0) begin
			other_errs++;
			$display("%s: halt, err or trace.valid not low after reset", name);
		end
		checking = 1'b1;
		run = 1'b1;
		cycles = 0;
		while (halt !== 1'b1 && cycles < HALT_TIMEOUT) begin
			@(negedge clk);
			cycles++;
		end
		if (halt !== 1'b1) begin
			timeout_errs++;
			$display("timeout: %s did not halt within %0d cycles", name, HALT_TIMEOUT);
		end else begin
			if (exp_q.size() != 0) begin
				missing_errs += exp_q.size();
				$display("%s: halt rose with %0d expected writes never traced", name,
					exp_q.size());
			end
			if (err !== exp_err) begin
				mismatch_errs++;
				$display("mismatch at %0t: %s err is %b, model gives %b", $time, name,
					err, exp_err);
			end
			// Quiet window after halt
			repeat (4) @(negedge clk);
		end
		@(posedge clk);
		checking = 1'b0;
		@(negedge clk);
		run = 1'b0;
	endtask

	always @(negedge clk) begin : compare_trace
		wb_trace_t want;
		if (rst_n && checking && trace.valid) begin
			if (halt) begin
				other_errs++;
				$display("trace beat at %0t while halt is high", $time);
			end else if (exp_q.size() == 0) begin
				extra_errs++;
				$display("extra trace at %0t: r%0d=%h beyond the model's writes", $time,
					trace.rd, trace.data);
			end else begin
				want = exp_q.pop_front();
				if (trace.rd !== want.rd || trace.data !== want.data) begin
					mismatch_errs++;
					$display("mismatch at %0t: trace r%0d=%h, model r%0d=%h", $time,
						trace.rd, trace.data, want.rd, want.data);
				end
			end
		end
	end

	initial begin
		rst_n = 1'b0;
		run = 1'b0;
		load_en = 1'b0;
		load_addr = '0;
		load_data = '0;
		checking = 1'b0;
		lfsr_state = 16'd55;
		mismatch_errs = 0;
		missing_errs = 0;
		extra_errs = 0;
		timeout_errs = 0;
		other_errs = 0;
		build_alu_chain();
		run_program("alu chain");
		build_load_store();
		run_program("load store");
		build_branch();
		run_program("branch");
		build_illegal();
		run_program("illegal opcode");
		for (int p = 0; p < 20; p++) begin
			build_random();
			run_program($sformatf("random program %0d", p));
		end
		total_errs = mismatch_errs + missing_errs + extra_errs + timeout_errs + other_errs +
			proc_inst.proc_checker_inst.fail_cnt;
		$display("errors: mismatch %0d missing %0d extra %0d timeout %0d other %0d assert %0d",
			mismatch_errs, missing_errs, extra_errs, timeout_errs, other_errs,
			proc_inst.proc_checker_inst.fail_cnt);
		if (total_errs == 0)
			$display("STATUS: PASS");
		else
			$display("STATUS: FAIL");
		$finish;
	end

endmodule

//--- sim.f
+incdir+hw
hw/proc_pkg.sv
hw/pipe_reg.sv
hw/fetch.sv
hw/decode.sv
hw/execute.sv
hw/memory.sv
hw/proc.sv
test/proc_checker.sv
test/proc_tb.sv
